// File: rtl/video_timing_pkg.sv
`default_nettype none

package video_timing_pkg;

	// horizontal timing, all in pixel periods (one cend each)
	localparam int H_PERIOD  = 448;	// full line
	localparam int HBLNK_BEG = 0;	// video ends, blank begins
	localparam int HSYNC_BEG = 10;	// sync pulse begins
	localparam int HSYNC_END = 43;	// 33 periods of sync
	localparam int HBLNK_END = 84;	// back porch done
	localparam int HPIX_BEG  = 148;	// 64 periods of border after blank
	localparam int HPIX_END  = 404;	// 256 pixel periods wide

	// where the frame interrupt starts inside its line
	// moved a few periods to line it up with the cpu clock
	localparam int HINT_BEG  = 3;

	// vertical timing, in lines
	localparam int V_PERIOD  = 320;	// lines per frame
	localparam int VBLNK_BEG = 0;
	localparam int VSYNC_BEG = 8;
	localparam int VSYNC_END = 16;	// 8 lines of vsync
	localparam int VBLNK_END = 32;
	localparam int VPIX_BEG  = 64;
	localparam int VPIX_END  = 256;	// 192 visible lines

	// int_n low time, counted in pixel periods
	localparam int INT_LEN   = 32;

	// counter widths
	localparam int HCNT_W    = 9;	// 0..447
	localparam int VCNT_W    = 9;	// 0..319

endpackage

`default_nettype wire

// File: rtl/video_color_pkg.sv
`default_nettype none

package video_color_pkg;

	// colour index is {bright, green, red, blue}
	localparam int COLOR_W = 4;

	// attribute byte layout
	// bits 2:0 ink, 5:3 paper, 6 bright, 7 flash (not used here)
	localparam int ATTR_INK_LSB   = 0;
	localparam int ATTR_PAPER_LSB = 3;
	localparam int ATTR_BRIGHT    = 6;

	// level forced during blanking
	localparam logic [COLOR_W-1:0] COLOR_BLACK = '0;

endpackage

`default_nettype wire

// File: rtl/clock_strobes.sv
`default_nettype none

module clock_strobes
	import video_timing_pkg::*;
#(
	parameter int CEND_DIV = 4	// clk cycles per pixel period (at least 2)
)
(
	input  logic clk,
	input  logic reset,
	output logic pre_cend,	// one clk ahead of cend
	output logic cend	// pixel rate strobe
);

	localparam int DIV_W     = (CEND_DIV > 2) ? $clog2(CEND_DIV) : 1;
	localparam int LINE_CLKS = H_PERIOD * CEND_DIV;	// clk cycles per raster line

	logic [DIV_W-1:0] div_cnt;	// runs 0 .. CEND_DIV-1

	// pre_cend needs a slot of its own before cend,
	// and a whole line must stay well inside a 16 bit span
	initial assert (CEND_DIV >= 2 && LINE_CLKS < 2**16)
		else $fatal(1, "clock_strobes: bad CEND_DIV %0d", CEND_DIV);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			div_cnt  <= '0;
			pre_cend <= 1'b0;
			cend     <= 1'b0;
		end
		else
		begin
			if (div_cnt == DIV_W'(CEND_DIV - 1))
				div_cnt <= '0;	// wrap
			else
				div_cnt <= div_cnt + 1'b1;
			pre_cend <= (div_cnt == DIV_W'(CEND_DIV - 2));	// sampled at count CEND_DIV-2
			cend     <= pre_cend;	// always exactly one clk later
		end
	end

	// the early strobes downstream depend on this pairing
	// cend has to land on the clk where the divider has just wrapped
	a_cend_after_pre: assert property (@(posedge clk) disable iff (reset)
		cend |-> $past(pre_cend) && div_cnt == '0);

endmodule

`default_nettype wire

// File: rtl/line_sync.sv
`default_nettype none

// horizontal part of the raster
//
// hcount   0     10         43        84           148            404      447
//          |blank|---sync---|  porch  | border      | pixels        | border |
//
// all levels move on cend, the early strobes are built on pre_cend
// so that they land on the same clk as the matching cend
module line_sync
	import video_timing_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic init,	// read at cend, restarts the line from hcount 0
	input  logic cend,
	input  logic pre_cend,
	output logic hblank,
	output logic hsync,
	output logic hpix,	// pixel window along the line
	output logic line_start,	// end of hblank, used to restart the pixel phase
	output logic hsync_start,	// coincides with the cend that raises hsync
	output logic hint_start	// position of the frame interrupt in the line
);

	logic [HCNT_W-1:0] hcount;	// pixel period within the line

	// phase adjustable counter
	always_ff @(posedge clk)
	begin
		if (reset)
			hcount <= '0;
		else if (cend)
		begin
			if (init || hcount == HCNT_W'(H_PERIOD - 1))
				hcount <= '0;
			else
				hcount <= hcount + 1'b1;
		end
	end

	// blank and sync levels
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hblank <= 1'b0;
			hsync  <= 1'b0;
		end
		else if (cend)
		begin
			if (hcount == HCNT_W'(HBLNK_BEG))
				hblank <= 1'b1;
			else if (hcount == HCNT_W'(HBLNK_END))
				hblank <= 1'b0;

			if (hcount == HCNT_W'(HSYNC_BEG))
				hsync <= 1'b1;
			else if (hcount == HCNT_W'(HSYNC_END))
				hsync <= 1'b0;
		end
	end

	// pixel window
	// an init inside the window lands on hcount 0, where blank starts,
	// so the window is closed there as well
	always_ff @(posedge clk)
	begin
		if (reset)
			hpix <= 1'b0;
		else if (cend)
		begin
			if (hcount == HCNT_W'(HPIX_BEG))
				hpix <= 1'b1;
			else if (hcount == HCNT_W'(HPIX_END) || hcount == HCNT_W'(HBLNK_BEG))
				hpix <= 1'b0;
		end
	end

	// one clk strobes, hcount here is the value the next cend will see
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hsync_start <= 1'b0;
			line_start  <= 1'b0;
			hint_start  <= 1'b0;
		end
		else
		begin
			hsync_start <= pre_cend && (hcount == HCNT_W'(HSYNC_BEG));
			line_start  <= pre_cend && (hcount == HCNT_W'(HBLNK_END));
			hint_start  <= pre_cend && (hcount == HCNT_W'(HINT_BEG));
		end
	end

	// sync must sit inside blank
	a_hsync_in_blank: assert property (@(posedge clk) disable iff (reset)
		hsync |-> hblank);

	// pixels never overlap blank, also across an init
	a_hpix_not_blank: assert property (@(posedge clk) disable iff (reset)
		!(hpix && hblank));

endmodule

`default_nettype wire

// File: rtl/frame_sync.sv
`default_nettype none

// vertical part of the raster, stepped once per line by hsync_start
// a line n starts at the hsync_start that sees vcount == n
module frame_sync
	import video_timing_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic cend,
	input  logic hsync_start,	// one per line
	input  logic hint_start,	// interrupt position in the line
	output logic vblank,
	output logic vsync,
	output logic vpix,	// visible lines
	output logic int_n	// frame interrupt, active low
);

	localparam int INT_W = $clog2(INT_LEN);

	logic [VCNT_W-1:0] vcount;	// line within the frame
	logic [INT_W-1:0]  int_cnt;	// pixel periods int_n has been low

	// line counter
	always_ff @(posedge clk)
	begin
		if (reset)
			vcount <= '0;
		else if (hsync_start)
		begin
			if (vcount == VCNT_W'(V_PERIOD - 1))
				vcount <= '0;
			else
				vcount <= vcount + 1'b1;
		end
	end

	// vertical levels, switched together with the line count
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			vblank <= 1'b0;
			vsync  <= 1'b0;
			vpix   <= 1'b0;
		end
		else if (hsync_start)
		begin
			if (vcount == VCNT_W'(VBLNK_BEG))
				vblank <= 1'b1;
			else if (vcount == VCNT_W'(VBLNK_END))
				vblank <= 1'b0;

			if (vcount == VCNT_W'(VSYNC_BEG))
				vsync <= 1'b1;
			else if (vcount == VCNT_W'(VSYNC_END))
				vsync <= 1'b0;

			if (vcount == VCNT_W'(VPIX_BEG))
				vpix <= 1'b1;
			else if (vcount == VCNT_W'(VPIX_END))
				vpix <= 1'b0;
		end
	end

	// frame interrupt
	// starts at the only hint_start of the frame with vcount at zero,
	// then runs for INT_LEN cend periods
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			int_n   <= 1'b1;
			int_cnt <= '0;
		end
		else if (hint_start && vcount == '0)
		begin
			int_n   <= 1'b0;
			int_cnt <= '0;
		end
		else if (!int_n && cend)
		begin
			if (int_cnt == INT_W'(INT_LEN - 1))
				int_n <= 1'b1;	// pulse over
			int_cnt <= int_cnt + 1'b1;
		end
	end

	// vsync is nested in vblank
	a_vsync_in_blank: assert property (@(posedge clk) disable iff (reset)
		vsync |-> vblank);

endmodule

`default_nettype wire

// File: rtl/video_mixer.sv
`default_nettype none

module video_mixer
	import video_timing_pkg::*;
	import video_color_pkg::*;
(
	input  logic               clk,
	input  logic               reset,
	input  logic               cend,
	input  logic               hblank,
	input  logic               vblank,
	input  logic               hsync,
	input  logic               vsync,
	input  logic               hpix,
	input  logic               vpix,
	input  logic               line_start,
	input  logic [COLOR_W-2:0] border,	// {green, red, blue}
	input  logic [7:0]         pix_byte,	// sampled on the byte_req clk
	input  logic [7:0]         attr_byte,
	output logic               byte_req,	// one clk wide with no back-pressure
	output logic [COLOR_W-1:0] color,
	output logic               blank,
	output logic               csync
);

	logic [2:0]         phase;	// pixel within the current byte
	logic [7:0]         pix_shift;	// msb is the next pixel
	logic [7:0]         attr_reg;
	logic               window;
	logic               pix_bit;
	logic [7:0]         attr_cur;
	logic [COLOR_W-2:0] ink;
	logic [COLOR_W-2:0] paper;

	// the window must hold whole bytes
	initial assert ((HPIX_END - HPIX_BEG) % 8 == 0)
		else $fatal(1, "video_mixer: pixel window not a multiple of 8");

	assign window   = hpix && vpix;
	assign byte_req = cend && window && (phase == '0);	// every 8th cend in the window

	// on a load the fresh byte is shown straight away
	assign pix_bit  = byte_req ? pix_byte[7] : pix_shift[7];
	assign attr_cur = byte_req ? attr_byte : attr_reg;
	assign ink      = attr_cur[ATTR_INK_LSB +: COLOR_W-1];
	assign paper    = attr_cur[ATTR_PAPER_LSB +: COLOR_W-1];

	always_ff @(posedge clk)
	begin
		if (reset)
			phase <= '0;
		else if (line_start)
			phase <= '0;	// realign before every window
		else if (cend && window)
			phase <= phase + 1'b1;
	end

	// pixel and attribute data
	always_ff @(posedge clk)
	begin
		if (byte_req)
		begin
			pix_shift <= {pix_byte[6:0], 1'b0};	// bit 7 already used
			attr_reg  <= attr_byte;
		end
		else if (cend)
			pix_shift <= {pix_shift[6:0], 1'b0};
	end

	// colour and blank move on cend and csync on every clk
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			color <= COLOR_BLACK;
			blank <= 1'b0;
			csync <= 1'b0;
		end
		else
		begin
			if (cend)
			begin
				blank <= hblank || vblank;	// kept in step with color
				if (hblank || vblank)
					color <= COLOR_BLACK;
				else if (window)
					color <= {attr_cur[ATTR_BRIGHT], pix_bit ? ink : paper};
				else
					color <= {1'b0, border};	// border is never bright
			end
			csync <= hsync ^ vsync;
		end
	end

	// requests never fall into blanking
	a_req_visible: assert property (@(posedge clk) disable iff (reset)
		byte_req |-> !hblank && !vblank);

endmodule

`default_nettype wire

// File: rtl/video_sync_top.sv
`default_nettype none

module video_sync_top
	import video_color_pkg::*;
#(
	parameter int CEND_DIV = 4	// clk cycles per pixel period
)
(
	input  logic               clk,
	input  logic               reset,
	input  logic               init,	// re-phases the line counter
	input  logic [COLOR_W-2:0] border,
	input  logic [7:0]         pix_byte,
	input  logic [7:0]         attr_byte,
	output logic               hsync,
	output logic               vsync,
	output logic               csync,
	output logic               blank,
	output logic [COLOR_W-1:0] color,
	output logic               int_n,
	output logic               byte_req
);

	logic pre_cend;
	logic cend;
	logic hblank;
	logic hpix;
	logic line_start;
	logic hsync_start;
	logic hint_start;
	logic vblank;
	logic vpix;

	// pixel strobes
	clock_strobes #(
		.CEND_DIV (CEND_DIV)
	) u_strobes (
		.clk      (clk),
		.reset    (reset),
		.pre_cend (pre_cend),
		.cend     (cend)
	);

	line_sync u_line (
		.clk         (clk),
		.reset       (reset),
		.init        (init),
		.cend        (cend),
		.pre_cend    (pre_cend),
		.hblank      (hblank),
		.hsync       (hsync),
		.hpix        (hpix),
		.line_start  (line_start),
		.hsync_start (hsync_start),
		.hint_start  (hint_start)
	);

	frame_sync u_frame (
		.clk         (clk),
		.reset       (reset),
		.cend        (cend),
		.hsync_start (hsync_start),
		.hint_start  (hint_start),
		.vblank      (vblank),
		.vsync       (vsync),
		.vpix        (vpix),
		.int_n       (int_n)
	);

	video_mixer u_mixer (
		.clk        (clk),
		.reset      (reset),
		.cend       (cend),
		.hblank     (hblank),
		.vblank     (vblank),
		.hsync      (hsync),
		.vsync      (vsync),
		.hpix       (hpix),
		.vpix       (vpix),
		.line_start (line_start),
		.border     (border),
		.pix_byte   (pix_byte),
		.attr_byte  (attr_byte),
		.byte_req   (byte_req),
		.color      (color),
		.blank      (blank),
		.csync      (csync)
	);

endmodule

`default_nettype wire

// File: verif/video_sync_tb.sv
`default_nettype none

module video_sync_tb
	import video_timing_pkg::*;
	import video_color_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CEND_DIV = 4;

	// expected timing in clk cycles
	localparam longint LINE_CLKS  = longint'(H_PERIOD * CEND_DIV);	// 1792
	localparam longint FRAME_CLKS = longint'(V_PERIOD) * LINE_CLKS;
	localparam longint HSYNC_CLKS = longint'((HSYNC_END - HSYNC_BEG) * CEND_DIV);
	localparam longint VSYNC_CLKS = longint'(VSYNC_END - VSYNC_BEG) * LINE_CLKS;
	localparam longint INT_CLKS   = longint'(INT_LEN * CEND_DIV);	// 128

	// a5 has four set bits in each of the 32 bytes of a visible line
	localparam int     PIX_BYTES       = (HPIX_END - HPIX_BEG) / 8;
	localparam longint INK_CLKS        = longint'(PIX_BYTES * 4 * CEND_DIV);
	localparam longint PAPER_CLKS      = longint'(PIX_BYTES * 4 * CEND_DIV);
	localparam longint BORDER_LINE_CLKS = longint'((H_PERIOD - HBLNK_END) * CEND_DIV);
	localparam longint BORDER_VIS_CLKS =
		longint'((H_PERIOD - HBLNK_END - (HPIX_END - HPIX_BEG)) * CEND_DIV);
	localparam longint VIS_LINES    = longint'(VPIX_END - VPIX_BEG);	// 192
	localparam longint BORDER_LINES = longint'(V_PERIOD - VBLNK_END - (VPIX_END - VPIX_BEG));

	localparam longint INIT_OFFSET   = 800;	// 200 pixel periods after an hsync rise
	localparam longint INIT_TO_HSYNC = longint'((HSYNC_BEG + 1) * CEND_DIV);	// 44

	// three frames plus a few lines
	localparam longint TIMEOUT_CYCLES = 3 * FRAME_CLKS + 8 * LINE_CLKS;

	// attribute under test has bright 1, paper 5 and ink 2
	localparam logic [7:0]         ATTR        = 8'h6A;
	localparam logic [COLOR_W-1:0] INK_COLOR   = {1'b1, 3'd2};
	localparam logic [COLOR_W-1:0] PAPER_COLOR = {1'b1, 3'd5};

	localparam int SEL_HSYNC = 0;
	localparam int SEL_VSYNC = 1;
	localparam int SEL_INT   = 2;

	logic               clk;
	logic               reset;
	logic               init;
	logic [COLOR_W-2:0] border;
	logic [7:0]         pix_byte;
	logic [7:0]         attr_byte;
	logic               hsync;
	logic               vsync;
	logic               csync;
	logic               blank;
	logic [COLOR_W-1:0] color;
	logic               int_n;
	logic               byte_req;

	longint cycle;	// posedges seen so far
	int     errors;
	int     checks;
	int     seed;

	video_sync_top #(
		.CEND_DIV (CEND_DIV)
	) uut (
		.clk       (clk),
		.reset     (reset),
		.init      (init),
		.border    (border),
		.pix_byte  (pix_byte),
		.attr_byte (attr_byte),
		.hsync     (hsync),
		.vsync     (vsync),
		.csync     (csync),
		.blank     (blank),
		.color     (color),
		.int_n     (int_n),
		.byte_req  (byte_req)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;	// 20 ns period
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	// watchdog
	initial
	begin
		while (cycle < TIMEOUT_CYCLES)
			@(posedge clk);
		$display("timeout: no result after %0d clock cycles", cycle);
		$display("SIMULATION FAILED");
		$finish;
	end

	task automatic compare_value(input string name, input longint got, input longint expected);
		checks++;
		assert (got == expected)
		else
		begin
			errors++;
			$display("ERROR at %0d ns: %s = %0d, expected %0d", $time, name, got, expected);
		end
	endtask

	function automatic logic signal_level(input int which);
		case (which)
			SEL_HSYNC: return hsync;
			SEL_VSYNC: return vsync;
			default:   return int_n;
		endcase
	endfunction

	// returns at the falling edge where the signal first shows level
	task automatic wait_edge(input int which, input logic level, output longint at);
		while (signal_level(which) == level)
			@(negedge clk);
		while (signal_level(which) != level)
			@(negedge clk);
		at = cycle;	// index of the posedge that moved it
	endtask

	task automatic reset_state_ok();
		compare_value("int_n after reset", longint'(int_n), 1);
		compare_value("color after reset", longint'(color), longint'(COLOR_BLACK));
		compare_value("byte_req after reset", longint'(byte_req), 0);
		compare_value("hsync after reset", longint'(hsync), 0);
		compare_value("vsync after reset", longint'(vsync), 0);
		compare_value("blank after reset", longint'(blank), 0);
	endtask

	task automatic measure_line_timing(input int lines);
		longint t_rise;
		longint t_fall;
		longint t_next;
		wait_edge(SEL_HSYNC, 1'b1, t_rise);
		repeat (lines)
		begin
			wait_edge(SEL_HSYNC, 1'b0, t_fall);
			compare_value("hsync high clocks", t_fall - t_rise, HSYNC_CLKS);
			wait_edge(SEL_HSYNC, 1'b1, t_next);
			compare_value("hsync period clocks", t_next - t_rise, LINE_CLKS);
			t_rise = t_next;
		end
	endtask

	task automatic measure_frame_timing();
		longint t_rise;
		longint t_fall;
		longint t_next;
		wait_edge(SEL_VSYNC, 1'b1, t_rise);	// line 8 of the first frame
		wait_edge(SEL_VSYNC, 1'b0, t_fall);
		compare_value("vsync high clocks", t_fall - t_rise, VSYNC_CLKS);
		wait_edge(SEL_VSYNC, 1'b1, t_next);
		compare_value("vsync period clocks", t_next - t_rise, FRAME_CLKS);
	endtask

	// csync is the xor of the syncs one clock back
	task automatic verify_csync(input longint n);
		logic hs_prev;
		logic vs_prev;
		hs_prev = hsync;
		vs_prev = vsync;
		repeat (n)
		begin
			@(negedge clk);
			compare_value("csync", longint'(csync), longint'(hs_prev ^ vs_prev));
			hs_prev = hsync;
			vs_prev = vsync;
		end
	endtask

	task automatic watch_interrupt();
		longint t_low;
		longint t_high;
		longint t_next;
		wait_edge(SEL_INT, 1'b0, t_low);	// fires in the first line after reset
		wait_edge(SEL_INT, 1'b1, t_high);
		compare_value("int_n low clocks", t_high - t_low, INT_CLKS);
		wait_edge(SEL_INT, 1'b0, t_next);	// no extra pulse in between
		compare_value("int_n period clocks", t_next - t_low, FRAME_CLKS);
		wait_edge(SEL_INT, 1'b1, t_high);
		compare_value("int_n low clocks", t_high - t_next, INT_CLKS);
	endtask

	// one frame split into lines at each hsync rise
	task automatic scan_pixels();
		longint ink_n;
		longint paper_n;
		longint border_n;
		longint vis_lines;
		longint border_lines;
		longint t;
		logic   prev_hs;
		vis_lines    = 0;
		border_lines = 0;
		wait_edge(SEL_HSYNC, 1'b1, t);	// first rise after reset opens line 0
		for (int line = 0; line < V_PERIOD; line++)
		begin
			ink_n    = 0;
			paper_n  = 0;
			border_n = 0;
			do
			begin
				prev_hs = hsync;
				@(negedge clk);
				if (blank)
					compare_value("color in blank", longint'(color), longint'(COLOR_BLACK));
				else if (color == INK_COLOR || color == PAPER_COLOR)
				begin
					// a5 opens every line with a set bit
					if (ink_n + paper_n == 0)
						compare_value("first pixel color", longint'(color),
							longint'(INK_COLOR));
					if (color == INK_COLOR)
						ink_n++;
					else
						paper_n++;
				end
				else
				begin
					compare_value("border color", longint'(color), longint'({1'b0, border}));
					border_n++;
				end
			end
			while (!(hsync && !prev_hs));
			if (ink_n + paper_n > 0)
			begin
				vis_lines++;
				compare_value("ink clocks per line", ink_n, INK_CLKS);
				compare_value("paper clocks per line", paper_n, PAPER_CLKS);
				compare_value("border clocks per visible line", border_n, BORDER_VIS_CLKS);
			end
			else if (border_n != 0)
			begin
				border_lines++;
				compare_value("border clocks per line", border_n, BORDER_LINE_CLKS);
			end
		end
		compare_value("visible lines", vis_lines, VIS_LINES);
		compare_value("border only lines", border_lines, BORDER_LINES);
	endtask

	task automatic count_byte_requests();
		longint reqs;
		longint req_lines;
		longint t;
		logic   prev_hs;
		req_lines = 0;
		wait_edge(SEL_HSYNC, 1'b1, t);
		repeat (V_PERIOD)
		begin
			reqs = 0;
			do
			begin
				prev_hs = hsync;
				@(negedge clk);
				if (byte_req)
					reqs++;	// each pulse is one clk wide
			end
			while (!(hsync && !prev_hs));
			if (reqs != 0)
			begin
				req_lines++;
				compare_value("byte_req pulses per line", reqs, longint'(PIX_BYTES));
			end
		end
		compare_value("lines with byte_req", req_lines, VIS_LINES);
	endtask

	// init seen at one cend restarts the line at hcount 0
	task automatic rephase_with_init();
		longint t_rise;
		longint t_next;
		wait_edge(SEL_HSYNC, 1'b1, t_rise);	// posedge t_rise carried a cend
		repeat (INIT_OFFSET - 2)
			@(negedge clk);
		init = 1'b1;	// covers posedges around t_rise + INIT_OFFSET
		repeat (4)
			@(negedge clk);
		init = 1'b0;
		wait_edge(SEL_HSYNC, 1'b1, t_next);
		compare_value("clocks from init to hsync", t_next - (t_rise + INIT_OFFSET), INIT_TO_HSYNC);
		t_rise = t_next;
		repeat (3)
		begin
			wait_edge(SEL_HSYNC, 1'b1, t_next);
			compare_value("hsync period after init", t_next - t_rise, LINE_CLKS);
			t_rise = t_next;
		end
	endtask

	initial
	begin
		seed      = 32'h4eadfb1a;
		errors    = 0;
		checks    = 0;
		reset     = 1'b1;
		init      = 1'b0;
		border    = '0;
		pix_byte  = 8'hA5;	// fixed pattern with ink on set bits
		attr_byte = ATTR;
		repeat (2)
			@(posedge clk);
		@(negedge clk);
		reset  = 1'b0;
		border = 3'($random(seed));
		reset_state_ok();
		fork
			measure_line_timing(4);
			measure_frame_timing();
			verify_csync(FRAME_CLKS);
			watch_interrupt();
			scan_pixels();
			count_byte_requests();
		join
		rephase_with_init();	// last since it moves the line phase
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
rtl/video_timing_pkg.sv
rtl/video_color_pkg.sv
rtl/clock_strobes.sv
rtl/line_sync.sv
rtl/frame_sync.sv
rtl/video_mixer.sv
rtl/video_sync_top.sv
verif/video_sync_tb.sv

// File: Makefile
SRCS := $(wildcard rtl/*.sv verif/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vvideo_sync_tb: src.f $(SRCS)
	verilator --binary --assert --timing --timescale 1ns/1ps \
		--top-module video_sync_tb -f src.f

run: obj_dir/Vvideo_sync_tb
	./obj_dir/Vvideo_sync_tb | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
